// ==== src.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_decoder.sv
rtl/hazard_detection_unit.sv
rtl/stage_tracker.sv
rtl/hazard_ctrl_top.sv
verification/tb_hazard_ctrl.sv

// ==== Bender.yml ====
package:
  name: hazard_ctrl

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/hazard_detection_unit.sv
      - rtl/stage_tracker.sv
      - rtl/hazard_ctrl_top.sv
  - target: test
    files:
      - verification/tb_hazard_ctrl.sv

// ==== verification/tb_hazard_ctrl.sv ====
// Self-checking testbench for hazard_ctrl_top; runs a hand-built table, then a random phase
`timescale 1ns/10ps

module tb_hazard_ctrl;

    localparam int RST_CYCLES  = 10;
    localparam int RAND_CYCLES = 200;

    logic              clk;
    logic              rst_n;
    logic              fetch_valid;
    isa_pkg::instr_t   fetch_instr;
    logic              stall;
    logic              issue;
    logic              illegal;
    logic              wb_valid;
    isa_pkg::reg_idx_t wb_dst;

    // Stimulus table, one entry per cycle
    logic              t_valid[$];
    isa_pkg::instr_t   t_instr[$];
    logic              t_stall[$];
    logic              t_issue[$];
    logic              t_ill[$];
    logic              t_wbv[$];
    isa_pkg::reg_idx_t t_wbd[$];

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000;
    logic [31:0] lcg_state = 32'h5e83b4e3;

    hazard_ctrl_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .issue       (issue),
        .illegal     (illegal),
        .wb_valid    (wb_valid),
        .wb_dst      (wb_dst)
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Hang guard, limit set once the table is built
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Register fields at their RV32I positions, funct3 and funct7 left zero
    function automatic isa_pkg::instr_t enc(input isa_pkg::opcode_t op,
                                            input isa_pkg::reg_idx_t rd,
                                            input isa_pkg::reg_idx_t rs1,
                                            input isa_pkg::reg_idx_t rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic isa_pkg::opcode_t pick_op(input int sel);
        case (sel)
            0: return isa_pkg::OP_REG;
            1: return isa_pkg::OP_IMM;
            2: return isa_pkg::OP_LOAD;
            3: return isa_pkg::OP_STORE;
            4: return isa_pkg::OP_BRANCH;
            5: return isa_pkg::OP_JALR;
            6: return isa_pkg::OP_JAL;
            7: return isa_pkg::OP_LUI;
            default: return isa_pkg::OP_AUIPC;
        endcase
    endfunction

    // Register usage per opcode, unused indices zero
    task automatic decode_model(input isa_pkg::instr_t ins, output isa_pkg::reg_idx_t s1,
                                output isa_pkg::reg_idx_t s2, output isa_pkg::reg_idx_t d,
                                output logic ill);
        s1 = '0;
        s2 = '0;
        d = '0;
        ill = 1'b0;
        case (ins[6:0])
            isa_pkg::OP_REG:
            begin
                s1 = ins[19:15];
                s2 = ins[24:20];
                d = ins[11:7];
            end
            isa_pkg::OP_IMM, isa_pkg::OP_LOAD, isa_pkg::OP_JALR:
            begin
                s1 = ins[19:15];
                d = ins[11:7];
            end
            isa_pkg::OP_STORE, isa_pkg::OP_BRANCH:
            begin
                s1 = ins[19:15];
                s2 = ins[24:20];
            end
            isa_pkg::OP_JAL, isa_pkg::OP_LUI, isa_pkg::OP_AUIPC:
                d = ins[11:7];
            default:
                ill = 1'b1;
        endcase
    endtask

    task automatic add_row(input logic v, input isa_pkg::instr_t ins, input logic st,
                           input logic is, input logic il, input logic wv,
                           input isa_pkg::reg_idx_t wd);
        t_valid.push_back(v);
        t_instr.push_back(ins);
        t_stall.push_back(st);
        t_issue.push_back(is);
        t_ill.push_back(il);
        t_wbv.push_back(wv);
        t_wbd.push_back(wd);
    endtask

    task automatic check_outputs(input logic e_stall, input logic e_issue, input logic e_ill,
                                 input logic e_wbv, input isa_pkg::reg_idx_t e_wbd,
                                 input int step);
        checks++;
        if (stall !== e_stall)
        begin
            errors++;
            $display("ERROR step %0d: stall expected 0x%0h got 0x%0h", step, e_stall, stall);
        end
        if (issue !== e_issue)
        begin
            errors++;
            $display("ERROR step %0d: issue expected 0x%0h got 0x%0h", step, e_issue, issue);
        end
        if (illegal !== e_ill)
        begin
            errors++;
            $display("ERROR step %0d: illegal expected 0x%0h got 0x%0h", step, e_ill, illegal);
        end
        if (wb_valid !== e_wbv)
        begin
            errors++;
            $display("ERROR step %0d: wb_valid expected 0x%0h got 0x%0h", step, e_wbv, wb_valid);
        end
        if (wb_dst !== e_wbd)
        begin
            errors++;
            $display("ERROR step %0d: wb_dst expected 0x%0h got 0x%0h", step, e_wbd, wb_dst);
        end
    endtask

    initial
    begin
        isa_pkg::instr_t   nop;
        isa_pkg::instr_t   cur;
        isa_pkg::reg_idx_t s1, s2, d;
        logic              ill, e_stall, e_issue, held, cur_v;
        logic              ex_v, mem_v, wb_v;
        isa_pkg::reg_idx_t ex_d, mem_d, wb_d;
        logic [31:0]       r;
        int                table_errors;

        nop = enc(isa_pkg::OP_IMM, 5'd0, 5'd0, 5'd0);
        // Idle after reset
        add_row(0, nop, 0, 0, 0, 0, 0);
        // add x1 then a reader of x1 stalls twice
        add_row(1, enc(isa_pkg::OP_REG, 5'd1, 5'd2, 5'd3), 0, 1, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd4, 5'd1, 5'd5), 1, 0, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd4, 5'd1, 5'd5), 1, 0, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd4, 5'd1, 5'd5), 0, 1, 0, 1, 5'd1);
        // One independent instruction between, single stall
        // Its immediate bits in the rs2 slot match x4 in execute but are not a source
        add_row(1, enc(isa_pkg::OP_IMM, 5'd6, 5'd7, 5'd4), 0, 1, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd8, 5'd4, 5'd0), 1, 0, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd8, 5'd4, 5'd0), 0, 1, 0, 1, 5'd4);
        // Load-use on rs1
        add_row(1, enc(isa_pkg::OP_LOAD, 5'd9, 5'd8, 5'd8), 1, 0, 0, 1, 5'd6);
        add_row(1, enc(isa_pkg::OP_LOAD, 5'd9, 5'd8, 5'd8), 1, 0, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_LOAD, 5'd9, 5'd8, 5'd8), 0, 1, 0, 1, 5'd8);
        // Store immediate bits match x9 in execute but are not a source
        add_row(1, enc(isa_pkg::OP_STORE, 5'd9, 5'd3, 5'd2), 0, 1, 0, 0, 0);
        // Branch waits on x9 in memory only
        add_row(1, enc(isa_pkg::OP_BRANCH, 5'd0, 5'd9, 5'd10), 1, 0, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_BRANCH, 5'd0, 5'd9, 5'd10), 0, 1, 0, 1, 5'd9);
        // LUI and JAL never stall, store writes back with zero dst
        add_row(1, enc(isa_pkg::OP_LUI, 5'd3, 5'd9, 5'd9), 0, 1, 0, 1, 5'd0);
        add_row(1, enc(isa_pkg::OP_JAL, 5'd5, 5'd3, 5'd3), 0, 1, 0, 0, 0);
        // jalr waits on rs1 only
        add_row(1, enc(isa_pkg::OP_JALR, 5'd6, 5'd5, 5'd3), 1, 0, 0, 1, 5'd0);
        add_row(1, enc(isa_pkg::OP_JALR, 5'd6, 5'd5, 5'd3), 1, 0, 0, 1, 5'd3);
        add_row(1, enc(isa_pkg::OP_JALR, 5'd6, 5'd5, 5'd3), 0, 1, 0, 1, 5'd5);
        add_row(1, enc(isa_pkg::OP_AUIPC, 5'd7, 5'd6, 5'd6), 0, 1, 0, 0, 0);
        // x0 users behind writers, including addi x0,x0,0
        add_row(1, nop, 0, 1, 0, 0, 0);
        add_row(1, enc(isa_pkg::OP_REG, 5'd0, 5'd0, 5'd0), 0, 1, 0, 1, 5'd6);
        // Illegal opcode issues with no registers
        add_row(1, enc(7'h7f, 5'd7, 5'd7, 5'd7), 0, 1, 1, 1, 5'd7);
        add_row(0, nop, 0, 0, 0, 1, 5'd0);
        add_row(0, nop, 0, 0, 0, 1, 5'd0);
        add_row(0, nop, 0, 0, 0, 1, 5'd0);
        add_row(0, nop, 0, 0, 0, 0, 0);
        limit = RST_CYCLES + t_instr.size() + RAND_CYCLES + 50;

        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = nop;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < t_instr.size(); i++)
        begin
            @(posedge clk);
            #1;
            fetch_valid = t_valid[i];
            fetch_instr = t_instr[i];
            #5;
            check_outputs(t_stall[i], t_issue[i], t_ill[i], t_wbv[i], t_wbd[i], i);
        end
        table_errors = errors;

        // Scoreboard of the three stages, empty after the table drains
        {ex_v, mem_v, wb_v} = '0;
        {ex_d, mem_d, wb_d} = '0;
        held = 1'b0;
        cur = nop;
        cur_v = 1'b0;
        for (int c = 0; c < RAND_CYCLES; c++)
        begin
            // Fetch holds its word while stalled
            if (!held)
            begin
                lcg_state = lcg_next(lcg_state);
                r = lcg_state;
                cur = enc(pick_op(r[31:28] % 9), {3'b000, r[27:26]}, {3'b000, r[25:24]},
                          {3'b000, r[23:22]});
                cur_v = (r[18:16] != 3'd0);
            end
            decode_model(cur, s1, s2, d, ill);
            e_stall = cur_v && (((s1 != '0) && ((s1 == ex_d) || (s1 == mem_d))) ||
                                ((s2 != '0) && ((s2 == ex_d) || (s2 == mem_d))));
            e_issue = cur_v && !e_stall;
            @(posedge clk);
            #1;
            fetch_valid = cur_v;
            fetch_instr = cur;
            #5;
            check_outputs(e_stall, e_issue, ill, wb_v, wb_d, t_instr.size() + c);
            held = e_stall;
            // Advance as the coming edge will
            wb_v = mem_v;
            wb_d = mem_d;
            mem_v = ex_v;
            mem_d = ex_d;
            ex_v = e_issue;
            ex_d = e_issue ? d : '0;
        end

        $display("Checks: %0d, errors: %0d (table %0d, random %0d)", checks, errors,
                 table_errors, errors - table_errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/hazard_ctrl_top.sv ====
// Operand hazard control top; decode usage, stall decision and stage tracking for fetch
`timescale 1ns/10ps

module hazard_ctrl_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  isa_pkg::instr_t   fetch_instr,
    output logic              stall,
    output logic              issue,
    output logic              illegal,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_dst
);

    // Decoded register usage
    isa_pkg::reg_idx_t    src1_idx;
    isa_pkg::reg_idx_t    src2_idx;
    isa_pkg::reg_idx_t    dst_idx;

    // In-flight destinations for comparison
    pipe_pkg::stage_dst_t ex_dst;
    pipe_pkg::stage_dst_t mem_dst;

    instr_decoder u_decoder (
        .fetch_instr (fetch_instr),
        .src1_idx    (src1_idx),
        .src2_idx    (src2_idx),
        .dst_idx     (dst_idx),
        .illegal     (illegal)
    );

    hazard_detection_unit u_hazard (
        .fetch_valid (fetch_valid),
        .src1_idx    (src1_idx),
        .src2_idx    (src2_idx),
        .ex_dst      (ex_dst),
        .mem_dst     (mem_dst),
        .stall       (stall),
        .issue       (issue)
    );

    // Issue gates entry into execute
    stage_tracker u_tracker (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .dst_idx  (dst_idx),
        .ex_dst   (ex_dst),
        .mem_dst  (mem_dst),
        .wb_valid (wb_valid),
        .wb_dst   (wb_dst)
    );

endmodule

// ==== rtl/stage_tracker.sv ====
// Destination tracking through execute, memory and writeback; feeds hazard compares and wb outputs
`timescale 1ns/10ps

module stage_tracker
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  isa_pkg::reg_idx_t    dst_idx,
    output pipe_pkg::stage_dst_t ex_dst,
    output pipe_pkg::stage_dst_t mem_dst,
    output logic                 wb_valid,
    output isa_pkg::reg_idx_t    wb_dst
);

    pipe_pkg::stage_vld_t ex_vld;
    pipe_pkg::stage_vld_t mem_vld;
    pipe_pkg::stage_vld_t wb_vld;

    // Three-deep chain that advances every edge
    // Nothing after decode can back-pressure
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Empty pipe with no pending writes
            ex_vld  <= 1'b0;
            ex_dst  <= '0;
            mem_vld <= 1'b0;
            mem_dst <= '0;
            wb_vld  <= 1'b0;
            wb_dst  <= '0;
        end
        else
        begin
            // Bubble with zero dst on any edge without issue
            ex_vld <= issue;
            ex_dst <= issue ? pipe_pkg::stage_dst_t'(dst_idx) : '0;

            // Execute to memory
            mem_vld <= ex_vld;
            mem_dst <= ex_dst;

            // Memory to writeback two edges after acceptance
            wb_vld <= mem_vld;
            wb_dst <= isa_pkg::reg_idx_t'(mem_dst);
        end
    end

    assign wb_valid = wb_vld;

    // A register write in writeback must belong to a real instruction
    a_wb_dst_has_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_dst != '0) |-> wb_valid
    )
    else $error("wb_dst nonzero without wb_valid");

    // Every accepted instruction occupies execute on the next cycle
    // and reaches writeback with its own destination two edges later
    a_issue_reaches_wb : assert property (
        @(posedge clk) disable iff (!rst_n)
        issue |=> ex_vld ##1 mem_vld ##1 (wb_valid && (wb_dst == $past(dst_idx, 3)))
    )
    else $error("accepted instruction lost between execute and writeback");

endmodule

// ==== rtl/hazard_detection_unit.sv ====
// Decode stall logic for a pipeline without forwarding; compares sources to in-flight destinations
`timescale 1ns/10ps

module hazard_detection_unit
(
    input  logic                 fetch_valid,
    input  isa_pkg::reg_idx_t    src1_idx,
    input  isa_pkg::reg_idx_t    src2_idx,
    input  pipe_pkg::stage_dst_t ex_dst,
    input  pipe_pkg::stage_dst_t mem_dst,
    output logic                 stall,
    output logic                 issue
);

    logic src1_live;
    logic src2_live;
    logic src1_hit;
    logic src2_hit;
    logic raw_hazard;

    // x0 reads never wait on anything
    // Also covers unused sources, which the decoder zeroes
    assign src1_live = (src1_idx != '0);
    assign src2_live = (src2_idx != '0);

    // Pending write in execute or memory
    // Writeback is excluded since the register file writes before decode reads
    assign src1_hit = src1_live &&
                      ((src1_idx == isa_pkg::reg_idx_t'(ex_dst)) ||
                       (src1_idx == isa_pkg::reg_idx_t'(mem_dst)));
    assign src2_hit = src2_live &&
                      ((src2_idx == isa_pkg::reg_idx_t'(ex_dst)) ||
                       (src2_idx == isa_pkg::reg_idx_t'(mem_dst)));

    // One rule for data, load-use, store-use, jump-use and branch-use
    // since the decoder already masked sources per opcode
    assign raw_hazard = src1_hit || src2_hit;

    // Only a valid decode slot can stall
    // Fetch must hold its word whenever stall is high
    assign stall = fetch_valid && raw_hazard;

    // Accepted at the next edge when high
    assign issue = fetch_valid && !raw_hazard;

endmodule

// ==== rtl/instr_decoder.sv ====
// Decode-stage register usage extraction; feeds the hazard unit with zeroed unused indices
`timescale 1ns/10ps

module instr_decoder
(
    input  isa_pkg::instr_t   fetch_instr,
    output isa_pkg::reg_idx_t src1_idx,
    output isa_pkg::reg_idx_t src2_idx,
    output isa_pkg::reg_idx_t dst_idx,
    output logic              illegal
);

    isa_pkg::opcode_t  opcode;
    isa_pkg::reg_idx_t rs1_field;
    isa_pkg::reg_idx_t rs2_field;
    isa_pkg::reg_idx_t rd_field;
    logic              use_rs1;
    logic              use_rs2;
    logic              use_rd;

    // Fixed RV32I field positions, same across all formats that carry them
    assign opcode    = fetch_instr[6:0];
    assign rd_field  = fetch_instr[11:7];
    assign rs1_field = fetch_instr[19:15];
    assign rs2_field = fetch_instr[24:20];

    // Per-opcode register usage
    always_comb
    begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            // Register-register ALU
            isa_pkg::OP_REG:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            // Single source, writes rd
            isa_pkg::OP_IMM, isa_pkg::OP_LOAD, isa_pkg::OP_JALR:
            begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            // Two sources, no writeback
            // Bits [11:7] are immediate here, not rd
            isa_pkg::OP_STORE, isa_pkg::OP_BRANCH:
            begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            // Immediate only, bits [24:15] are not registers
            isa_pkg::OP_JAL, isa_pkg::OP_LUI, isa_pkg::OP_AUIPC:
            begin
                use_rd = 1'b1;
            end
            // Outside RV32I, issues as a no-register slot
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

    // Unused fields forced to x0 so hazard compares can ignore the format
    assign src1_idx = use_rs1 ? rs1_field : '0;
    assign src2_idx = use_rs2 ? rs2_field : '0;
    assign dst_idx  = use_rd  ? rd_field  : '0;

endmodule

// ==== rtl/pipe_pkg.sv ====
// Pipeline-side types for tracked stage state, used by the stage tracker and hazard unit
`include "pipe_macros.svh"

package pipe_pkg;

    // Destination register held by a tracked stage
    // Zero means the stage writes nothing, either a bubble or an rd of x0
    typedef logic [`PIPE_REG_IDX_W-1:0] stage_dst_t;

    // Stage occupied flag
    // High for any accepted instruction, including illegal ones with no rd
    typedef logic stage_vld_t;

    // Stage order after decode
    // Execute, then memory, then writeback
    // Writeback never compares since the register file writes before read

endpackage

// ==== rtl/isa_pkg.sv ====
// ISA-level types and RV32I major opcodes, referenced by scoped name from decode and the testbench
`include "pipe_macros.svh"

package isa_pkg;

    // Raw instruction word as held by fetch
    typedef logic [`PIPE_XLEN-1:0] instr_t;

    // Architectural register index, x0 is hardwired zero
    typedef logic [`PIPE_REG_IDX_W-1:0] reg_idx_t;

    // Major opcode field
    typedef logic [`PIPE_OPCODE_W-1:0] opcode_t;

    // R-type ALU ops, read rs1/rs2 and write rd
    localparam opcode_t OP_REG    = 7'b0110011;
    // I-type ALU ops
    localparam opcode_t OP_IMM    = 7'b0010011;
    // Loads, base register in rs1
    localparam opcode_t OP_LOAD   = 7'b0000011;
    // Stores, base in rs1 and data in rs2
    localparam opcode_t OP_STORE  = 7'b0100011;
    // Conditional branches compare rs1 and rs2
    localparam opcode_t OP_BRANCH = 7'b1100011;
    // Indirect jump, target from rs1, link to rd
    localparam opcode_t OP_JALR   = 7'b1100111;
    // Direct jump, link only
    localparam opcode_t OP_JAL    = 7'b1101111;
    // Upper immediate forms, no register source
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

endpackage

// ==== rtl/pipe_macros.svh ====
// Width constants shared by the ISA and pipeline packages; include before either package
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Instruction word width for RV32I
`define PIPE_XLEN 32

// Register index width, 32 architectural registers
`define PIPE_REG_IDX_W 5

// Major opcode field width, bits [6:0] of the word
`define PIPE_OPCODE_W 7

// Widths must stay consistent with the fixed RV32I field positions
// used in the decoder (rd at [11:7], rs1 at [19:15], rs2 at [24:20])

`endif
